//--- common/secv_pkg.sv
// Shared widths, types and encodings for the memory side of the core, imported by every RTL module
package secv_pkg;

    // Word index width, 256 doublewords
    localparam int ADDR_WIDTH = 8;

    // Reset also clears the memory array when set
    localparam bit RESET_MEM = 1'b1;

    typedef logic [ADDR_WIDTH+2:0] baddr_t;
    typedef logic [ADDR_WIDTH-1:0] waddr_t;
    typedef logic [31:0]           inst_t;
    typedef logic [63:0]           dword_t;
    typedef logic [7:0]            dsel_t;
    typedef logic [3:0]            isel_t;

    // Byte offset inside a doubleword, and log2 of the access size
    typedef logic [2:0] boffs_t;
    typedef logic [1:0] lsize_t;

    typedef enum logic [3:0] {
        LB,
        LH,
        LW,
        LD,
        LBU,
        LHU,
        LWU,
        SB,
        SH,
        SW,
        SD
    } ls_op_e;

    // Command as it enters the load/store unit
    typedef struct packed {
        ls_op_e op;
        baddr_t addr;
        dword_t wdata;
    } ls_cmd_t;

    // Decoded command, wdata already in lane position
    typedef struct packed {
        waddr_t waddr;
        dsel_t  sel;
        dword_t wdata;
        logic   we;
        boffs_t offs;
        lsize_t size;
        logic   sgn;
        logic   misal;
    } ls_dec_t;

    typedef struct packed {
        dword_t data;
        logic   err;
        logic   store;
    } ls_res_t;

    // Wishbone master states for fetch and data port
    typedef enum logic {
        IDLE,
        REQ
    } wb_state_e;

endpackage

//--- ram/ram_2port_wb.sv
// Dual-port Wishbone RAM: port 1 reads 32-bit instructions, port 2 reads and writes 64-bit data
`timescale 1ns/1ps

module ram_2port_wb
    import secv_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_i,

    // Port 1, instruction read
    input  logic   cyc1_i,
    input  logic   stb1_i,
    input  isel_t  sel1_i,
    input  baddr_t adr1_i,
    output inst_t  dat1_o,
    output logic   ack1_o,

    // Port 2, data read and write
    input  logic   cyc2_i,
    input  logic   stb2_i,
    input  dsel_t  sel2_i,
    input  waddr_t adr2_i,
    input  logic   we2_i,
    input  dword_t dat2_i,
    output dword_t dat2_o,
    output logic   ack2_o
);

    dword_t mem [2**ADDR_WIDTH];

    logic   req1;
    logic   req2;
    waddr_t iword;
    inst_t  ihalf;

    // A new request only while our own ack is low
    assign req1 = cyc1_i && stb1_i && !ack1_o;
    assign req2 = cyc2_i && stb2_i && !ack2_o;

    // Byte address bit 2 picks the upper instruction of a doubleword
    assign iword = adr1_i[ADDR_WIDTH+2:3];
    assign ihalf = adr1_i[2] ? mem[iword][63:32] : mem[iword][31:0];

    // Port 1
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack1_o <= 1'b0;
            dat1_o <= '0;
        end else begin
            ack1_o <= req1;
            if (req1) begin
                for (int b = 0; b < 4; b++) begin
                    dat1_o[b*8 +: 8] <= sel1_i[b] ? ihalf[b*8 +: 8] : 8'h00;
                end
            end
        end
    end

    // Port 2 with array write
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack2_o <= 1'b0;
            dat2_o <= '0;
            if (RESET_MEM) begin
                for (int w = 0; w < 2**ADDR_WIDTH; w++) begin
                    mem[w] <= '0;
                end
            end
        end else begin
            ack2_o <= req2;
            if (req2) begin
                if (we2_i) begin
                    for (int b = 0; b < 8; b++) begin
                        if (sel2_i[b]) begin
                            mem[adr2_i][b*8 +: 8] <= dat2_i[b*8 +: 8];
                        end
                    end
                    dat2_o <= '0;
                end else begin
                    // Unselected lanes read as zero
                    for (int b = 0; b < 8; b++) begin
                        dat2_o[b*8 +: 8] <= sel2_i[b] ? mem[adr2_i][b*8 +: 8] : 8'h00;
                    end
                end
            end
        end
    end

endmodule

//--- source/ifetch.sv
// Instruction fetch master, one Wishbone read on port 1 per accepted pc
`timescale 1ns/1ps

module ifetch
    import secv_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_i,

    input  logic   fetch_valid_i,
    input  baddr_t fetch_pc_i,
    output logic   fetch_ready_o,
    output logic   inst_valid_o,
    output inst_t  inst_o,

    // Wishbone port 1
    output logic   cyc_o,
    output logic   stb_o,
    output isel_t  sel_o,
    output baddr_t adr_o,
    input  inst_t  dat_i,
    input  logic   ack_i
);

    wb_state_e state_q;
    baddr_t    pc_q;

    assign fetch_ready_o = (state_q == IDLE);

    assign cyc_o = (state_q == REQ);
    assign stb_o = (state_q == REQ);
    assign sel_o = 4'hF;
    assign adr_o = pc_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q      <= IDLE;
            inst_valid_o <= 1'b0;
        end else begin
            inst_valid_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (fetch_valid_i) begin
                        state_q <= REQ;
                    end
                end
                REQ: begin
                    if (ack_i) begin
                        state_q      <= IDLE;
                        inst_valid_o <= 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Instructions are word aligned, low pc bits dropped
    always_ff @(posedge clk_i) begin
        if (fetch_valid_i && fetch_ready_o) begin
            pc_q <= fetch_pc_i & ~baddr_t'(3);
        end
        if (state_q == REQ && ack_i) begin
            inst_o <= dat_i;
        end
    end

endmodule

//--- lsu/lsu_decode.sv
// Load/store decode stage, turns an accepted command into bus lanes and a misalignment flag
`timescale 1ns/1ps

module lsu_decode
    import secv_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    ls_valid_i,
    input  ls_cmd_t ls_cmd_i,
    input  logic    busy_i,
    output logic    ls_ready_o,
    output logic    dec_valid_o,
    output ls_dec_t dec_o
);

    lsize_t size;
    logic   sgn;
    logic   we;
    boffs_t offs;
    dsel_t  mask;

    assign ls_ready_o = !busy_i && !dec_valid_o;
    assign offs       = ls_cmd_i.addr[2:0];

    always_comb begin
        sgn = 1'b0;
        we  = 1'b0;
        case (ls_cmd_i.op)
            LB:      begin size = 2'd0; sgn = 1'b1; end
            LH:      begin size = 2'd1; sgn = 1'b1; end
            LW:      begin size = 2'd2; sgn = 1'b1; end
            LBU:     size = 2'd0;
            LHU:     size = 2'd1;
            LWU:     size = 2'd2;
            SB:      begin size = 2'd0; we = 1'b1; end
            SH:      begin size = 2'd1; we = 1'b1; end
            SW:      begin size = 2'd2; we = 1'b1; end
            SD:      begin size = 2'd3; we = 1'b1; end
            default: size = 2'd3;
        endcase
        // Lanes covered by the access before shifting
        mask = dsel_t'((9'd1 << (4'd1 << size)) - 9'd1);
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= ls_valid_i && ls_ready_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ls_valid_i && ls_ready_o) begin
            dec_o.waddr <= ls_cmd_i.addr[ADDR_WIDTH+2:3];
            dec_o.sel   <= mask << offs;
            dec_o.wdata <= ls_cmd_i.wdata << {offs, 3'b000};
            dec_o.we    <= we;
            dec_o.offs  <= offs;
            dec_o.size  <= size;
            dec_o.sgn   <= sgn;
            // Offset must be a multiple of the access size
            dec_o.misal <= (offs & boffs_t'((4'd1 << size) - 4'd1)) != 3'd0;
        end
    end

endmodule

//--- lsu/lsu_execute.sv
// Load/store execute stage, runs the Wishbone classic cycle on the data port
`timescale 1ns/1ps

module lsu_execute
    import secv_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    dec_valid_i,
    input  ls_dec_t dec_i,
    output logic    busy_o,
    output logic    exe_valid_o,
    output ls_dec_t exe_o,
    output dword_t  rdata_o,

    // Wishbone port 2
    output logic    cyc_o,
    output logic    stb_o,
    output dsel_t   sel_o,
    output waddr_t  adr_o,
    output logic    we_o,
    output dword_t  dat_o,
    input  dword_t  dat_i,
    input  logic    ack_i
);

    wb_state_e state_q;
    ls_dec_t   cmd_q;
    // Misaligned command waiting one cycle in place of a bus cycle
    logic      bypass_q;

    // Bus fields stay stable from cmd_q until ack
    assign cyc_o = (state_q == REQ);
    assign stb_o = (state_q == REQ);
    assign sel_o = cmd_q.sel;
    assign adr_o = cmd_q.waddr;
    assign we_o  = cmd_q.we;
    assign dat_o = cmd_q.wdata;

    // Read data is valid in the ack cycle, the result stage latches it
    assign exe_valid_o = bypass_q || (state_q == REQ && ack_i);
    assign exe_o       = cmd_q;
    assign rdata_o     = dat_i;

    // Result pulse is registered on the same edge as the return to IDLE
    assign busy_o = (state_q == REQ) || bypass_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q  <= IDLE;
            bypass_q <= 1'b0;
        end else begin
            bypass_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (dec_valid_i) begin
                        if (dec_i.misal) begin
                            bypass_q <= 1'b1;
                        end else begin
                            state_q <= REQ;
                        end
                    end
                end
                REQ: begin
                    if (ack_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (dec_valid_i) begin
            cmd_q <= dec_i;
        end
    end

endmodule

//--- lsu/lsu_result.sv
// Load/store result stage, aligns and extends load data and pulses the result
`timescale 1ns/1ps

module lsu_result
    import secv_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    exe_valid_i,
    input  ls_dec_t exe_i,
    input  dword_t  rdata_i,
    output logic    res_valid_o,
    output ls_res_t res_o
);

    dword_t shifted;
    dword_t ext;

    // Move the addressed bytes down to lane 0
    assign shifted = rdata_i >> {exe_i.offs, 3'b000};

    always_comb begin
        case (exe_i.size)
            2'd0:    ext = {{56{exe_i.sgn & shifted[7]}}, shifted[7:0]};
            2'd1:    ext = {{48{exe_i.sgn & shifted[15]}}, shifted[15:0]};
            2'd2:    ext = {{32{exe_i.sgn & shifted[31]}}, shifted[31:0]};
            default: ext = shifted;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= exe_valid_i;
        end
    end

    // Stores and faults return zero data
    always_ff @(posedge clk_i) begin
        if (exe_valid_i) begin
            res_o.data  <= (exe_i.we || exe_i.misal) ? '0 : ext;
            res_o.err   <= exe_i.misal;
            res_o.store <= exe_i.we;
        end
    end

endmodule

//--- source/secv_mem_top.sv
// Memory subsystem top level, joins instruction fetch, the load/store stages and the RAM
`timescale 1ns/1ps

module secv_mem_top
    import secv_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,

    // Fetch side
    input  logic    fetch_valid_i,
    input  baddr_t  fetch_pc_i,
    output logic    fetch_ready_o,
    output logic    inst_valid_o,
    output inst_t   inst_o,

    // Load/store side
    input  logic    ls_valid_i,
    input  ls_cmd_t ls_cmd_i,
    output logic    ls_ready_o,
    output logic    res_valid_o,
    output ls_res_t res_o
);

    // Port 1
    logic    cyc1;
    logic    stb1;
    isel_t   sel1;
    baddr_t  adr1;
    inst_t   dat1;
    logic    ack1;

    // Port 2
    logic    cyc2;
    logic    stb2;
    dsel_t   sel2;
    waddr_t  adr2;
    logic    we2;
    dword_t  wdat2;
    dword_t  rdat2;
    logic    ack2;

    // Between the load/store stages
    logic    dec_valid;
    ls_dec_t dec;
    logic    exe_busy;
    logic    exe_valid;
    ls_dec_t exe;
    dword_t  rdata;

    ifetch u_ifetch (
        .clk_i, .rst_i, .fetch_valid_i, .fetch_pc_i, .fetch_ready_o, .inst_valid_o, .inst_o,
        .cyc_o(cyc1), .stb_o(stb1), .sel_o(sel1), .adr_o(adr1), .dat_i(dat1), .ack_i(ack1)
    );

    lsu_decode u_decode (
        .clk_i, .rst_i, .ls_valid_i, .ls_cmd_i, .busy_i(exe_busy), .ls_ready_o,
        .dec_valid_o(dec_valid), .dec_o(dec)
    );

    lsu_execute u_execute (
        .clk_i, .rst_i, .dec_valid_i(dec_valid), .dec_i(dec), .busy_o(exe_busy),
        .exe_valid_o(exe_valid), .exe_o(exe), .rdata_o(rdata),
        .cyc_o(cyc2), .stb_o(stb2), .sel_o(sel2), .adr_o(adr2), .we_o(we2),
        .dat_o(wdat2), .dat_i(rdat2), .ack_i(ack2)
    );

    lsu_result u_result (
        .clk_i, .rst_i, .exe_valid_i(exe_valid), .exe_i(exe), .rdata_i(rdata),
        .res_valid_o, .res_o
    );

    ram_2port_wb u_ram (
        .clk_i, .rst_i,
        .cyc1_i(cyc1), .stb1_i(stb1), .sel1_i(sel1), .adr1_i(adr1),
        .dat1_o(dat1), .ack1_o(ack1),
        .cyc2_i(cyc2), .stb2_i(stb2), .sel2_i(sel2), .adr2_i(adr2), .we2_i(we2),
        .dat2_i(wdat2), .dat2_o(rdat2), .ack2_o(ack2)
    );

endmodule

//--- tb/secv_mem_assertions.sv
// Wishbone handshake checks on both RAM ports, bound into the RAM from the testbench
`timescale 1ns/1ps

module secv_mem_assertions (
    input logic clk_i,
    input logic rst_i,
    input logic cyc1_i,
    input logic stb1_i,
    input logic ack1_i,
    input logic cyc2_i,
    input logic stb2_i,
    input logic ack2_i
);

    // Ack only in the cycle after a strobe
    a_ack1_after_stb: assert property (@(posedge clk_i) disable iff (rst_i)
        ack1_i |-> $past(stb1_i)) else $error("port 1 ack without a preceding strobe");
    a_ack2_after_stb: assert property (@(posedge clk_i) disable iff (rst_i)
        ack2_i |-> $past(stb2_i)) else $error("port 2 ack without a preceding strobe");

    a_stb1_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
        stb1_i |-> cyc1_i) else $error("port 1 strobe outside a bus cycle");
    a_stb2_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
        stb2_i |-> cyc2_i) else $error("port 2 strobe outside a bus cycle");

    // One ack per request
    a_ack1_single: assert property (@(posedge clk_i) disable iff (rst_i)
        ack1_i |=> !ack1_i) else $error("port 1 ack in two consecutive cycles");
    a_ack2_single: assert property (@(posedge clk_i) disable iff (rst_i)
        ack2_i |=> !ack2_i) else $error("port 2 ack in two consecutive cycles");

endmodule

//--- tb/tb_secv_mem.sv
// Table-driven testbench for the memory subsystem that runs as simulation top against a byte model
`timescale 1ns/1ps

module tb_secv_mem
    import secv_pkg::*;
();

    typedef struct packed {
        int         group;
        logic [1:0] kind;
        ls_cmd_t    cmd;
        baddr_t     pc;
        ls_res_t    exp_res;
        inst_t      exp_inst;
        int         exp_lat;
    } entry_t;

    localparam logic [1:0] K_LS    = 2'd0;
    localparam logic [1:0] K_FETCH = 2'd1;
    localparam logic [1:0] K_BOTH  = 2'd2;

    logic    clk_i = 1'b0;
    logic    rst_i;
    logic    fetch_valid_i;
    baddr_t  fetch_pc_i;
    logic    fetch_ready_o;
    logic    inst_valid_o;
    inst_t   inst_o;
    logic    ls_valid_i;
    ls_cmd_t ls_cmd_i;
    logic    ls_ready_o;
    logic    res_valid_o;
    ls_res_t res_o;

    // Little endian byte model of the RAM
    logic [7:0]  shadow [2**(ADDR_WIDTH+3)];
    entry_t      tests_q [$];
    logic [31:0] rng = 32'd45096;
    int          checks = 0;
    int          errors = 0;
    int unsigned cycles = 0;
    int unsigned limit = 0;
    string       test_names [1:6] = '{"reset contents", "store then load", "load extension",
                                      "fetch halves", "misaligned access", "fetch with load"};

    secv_mem_top uut (.*);

    bind ram_2port_wb secv_mem_assertions u_wb_checks (
        .clk_i, .rst_i, .cyc1_i, .stb1_i, .ack1_i(ack1_o), .cyc2_i, .stb2_i, .ack2_i(ack2_o)
    );

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("Something failed");
            $display("timeout: run did not finish within %0d cycles", limit);
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic dword_t rand64();
        rng = xorshift(rng);
        rand64[63:32] = rng;
        rng = xorshift(rng);
        rand64[31:0] = rng;
    endfunction

    // Little endian read of n model bytes
    function automatic dword_t peek(input int addr, input int n);
        dword_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = v | (dword_t'(shadow[baddr_t'(addr + i)]) << (8 * i));
        end
        return v;
    endfunction

    // Appends a load or store with its predicted result and updates the model for stores
    task automatic add_ls(input int group, input ls_op_e op, input int addr, input dword_t data);
        entry_t e;
        int     n;
        dword_t v;
        case (op)
            LB, LBU, SB: n = 1;
            LH, LHU, SH: n = 2;
            LW, LWU, SW: n = 4;
            default:     n = 8;
        endcase
        e = '0;
        e.group = group;
        e.kind = K_LS;
        e.cmd.op = op;
        e.cmd.addr = baddr_t'(addr);
        e.cmd.wdata = data;
        e.exp_res.store = op inside {SB, SH, SW, SD};
        e.exp_res.err = (addr % n) != 0;
        e.exp_lat = e.exp_res.err ? 3 : 4;
        if (!e.exp_res.err && e.exp_res.store) begin
            for (int i = 0; i < n; i++) begin
                shadow[baddr_t'(addr + i)] = 8'(data >> (8 * i));
            end
        end else if (!e.exp_res.err) begin
            v = peek(addr, n);
            // Sign bit sits at the top of the accessed width
            if (op inside {LB, LH, LW} && (v >> (n * 8 - 1)) != 0) begin
                v = v | (~64'd0 << (n * 8));
            end
            e.exp_res.data = v;
        end
        tests_q.push_back(e);
    endtask

    // Appends a fetch or pairs it with the last load so both go out in one cycle
    task automatic add_fetch(input int group, input int pc, input bit paired);
        entry_t e;
        if (paired) begin
            e = tests_q.pop_back();
            e.kind = K_BOTH;
        end else begin
            e = '0;
            e.group = group;
            e.kind = K_FETCH;
        end
        e.pc = baddr_t'(pc);
        e.exp_inst = inst_t'(peek(pc & ~3, 4));
        tests_q.push_back(e);
    endtask

    task automatic check(input string name, input dword_t got, input dword_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_lat(input string what, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("%s arrived after %0d cycles instead of %0d", what, got, exp);
        end
    endtask

    task automatic run_entry(input entry_t e);
        bit want_ls;
        bit want_f;
        int lat;
        want_ls = (e.kind != K_FETCH);
        want_f = (e.kind != K_LS);
        @(negedge clk_i);
        while ((want_ls && !ls_ready_o) || (want_f && !fetch_ready_o)) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        ls_valid_i <= want_ls;
        ls_cmd_i <= e.cmd;
        fetch_valid_i <= want_f;
        fetch_pc_i <= e.pc;
        // Latency counts from the acceptance edge
        @(posedge clk_i);
        ls_valid_i <= 1'b0;
        fetch_valid_i <= 1'b0;
        lat = 0;
        while (want_ls || want_f) begin
            @(negedge clk_i);
            lat++;
            // Inputs stay blocked while a request is in flight
            if (want_ls && !res_valid_o) begin
                check("ls_ready_o", dword_t'(ls_ready_o), '0);
            end
            if (want_f && !inst_valid_o) begin
                check("fetch_ready_o", dword_t'(fetch_ready_o), '0);
            end
            if (want_ls && res_valid_o) begin
                want_ls = 1'b0;
                check_lat("load/store result", lat, e.exp_lat);
                check("res_o.data", res_o.data, e.exp_res.data);
                check("res_o.err", dword_t'(res_o.err), dword_t'(e.exp_res.err));
                check("res_o.store", dword_t'(res_o.store), dword_t'(e.exp_res.store));
            end
            if (want_f && inst_valid_o) begin
                want_f = 1'b0;
                check_lat("instruction", lat, 3);
                check("inst_o", dword_t'(inst_o), dword_t'(e.exp_inst));
            end
        end
    endtask

    initial begin
        int grp_chk;
        int grp_err;
        rst_i = 1'b1;
        fetch_valid_i = 1'b0;
        fetch_pc_i = '0;
        ls_valid_i = 1'b0;
        ls_cmd_i = '0;
        for (int i = 0; i < 2**(ADDR_WIDTH+3); i++) begin
            shadow[baddr_t'(i)] = 8'h00;
        end

        for (int w = 0; w < 2**ADDR_WIDTH; w++) begin
            add_ls(1, LD, w * 8, '0);
            add_fetch(1, w * 8, 1'b0);
            add_fetch(1, w * 8 + 4, 1'b0);
        end

        add_ls(2, SD, 256, rand64());
        add_ls(2, LD, 256, '0);
        for (int a = 264; a <= 280; a += 8) begin
            add_ls(2, SD, a, rand64());
        end
        for (int o = 0; o < 8; o++) begin
            add_ls(2, SB, 264 + o, rand64());
            add_ls(2, LD, 264, '0);
            if (o % 2 == 0) begin
                add_ls(2, SH, 272 + o, rand64());
                add_ls(2, LD, 272, '0);
            end
            if (o % 4 == 0) begin
                add_ls(2, SW, 280 + o, rand64());
                add_ls(2, LD, 280, '0);
            end
        end

        // Bytes, halves and words with the top bit both set and clear
        add_ls(3, SD, 320, 64'h5aa5_1290_01ff_7f80);
        add_ls(3, SD, 328, 64'h7f80_ff01_8090_a512);
        for (int o = 0; o < 16; o++) begin
            add_ls(3, LB, 320 + o, '0);
            add_ls(3, LBU, 320 + o, '0);
            if (o % 2 == 0) begin
                add_ls(3, LH, 320 + o, '0);
                add_ls(3, LHU, 320 + o, '0);
            end
            if (o % 4 == 0) begin
                add_ls(3, LW, 320 + o, '0);
                add_ls(3, LWU, 320 + o, '0);
            end
        end

        for (int a = 384; a < 408; a += 8) begin
            add_ls(4, SD, a, rand64());
            add_fetch(4, a, 1'b0);
            add_fetch(4, a + 4, 1'b0);
        end
        add_fetch(4, 390, 1'b0);

        add_ls(5, SD, 448, rand64());
        for (int o = 1; o < 8; o++) begin
            if (o % 2 != 0) begin
                add_ls(5, LH, 448 + o, '0);
                add_ls(5, SH, 448 + o, rand64());
            end
            if (o % 4 != 0) begin
                add_ls(5, LW, 448 + o, '0);
                add_ls(5, SW, 448 + o, rand64());
            end
            add_ls(5, LD, 448 + o, '0);
            add_ls(5, SD, 448 + o, rand64());
        end
        add_ls(5, LD, 448, '0);

        add_ls(6, SD, 512, rand64());
        add_ls(6, LD, 512, '0);
        add_fetch(6, 516, 1'b1);
        add_ls(6, LWU, 516, '0);
        add_fetch(6, 512, 1'b1);
        add_ls(6, LB, 515, '0);
        add_fetch(6, 264, 1'b1);

        limit = tests_q.size() * 10 + 200;
        repeat (10) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        checks++;
        assert (ls_ready_o && fetch_ready_o && !inst_valid_o && !res_valid_o) else begin
            errors++;
            $display("ready outputs are not both high or a valid output is high after reset");
        end

        grp_chk = checks;
        grp_err = errors;
        foreach (tests_q[i]) begin
            run_entry(tests_q[i]);
            if (i == tests_q.size() - 1 || tests_q[i + 1].group != tests_q[i].group) begin
                $display("test %0d %s: %0d checks, %0d errors", tests_q[i].group,
                         test_names[3'(tests_q[i].group)], checks - grp_chk, errors - grp_err);
                grp_chk = checks;
                grp_err = errors;
            end
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- tb.f
common/secv_pkg.sv
ram/ram_2port_wb.sv
source/ifetch.sv
lsu/lsu_decode.sv
lsu/lsu_execute.sv
lsu/lsu_result.sv
source/secv_mem_top.sv
tb/secv_mem_assertions.sv
tb/tb_secv_mem.sv

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run the testbench and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_secv_mem -f tb.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "build or simulation stopped with an error" >> sim.log

cat sim.log
grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Everything OK" sim.log || { echo "FAIL: run did not complete"; exit 1; }
echo "PASS"
